// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pipeHazardTb
SEED      ?= 0
FILELIST  ?= pipeHazard.f
OBJDIR    ?= obj_dir

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJDIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf $(OBJDIR)

// ==== hdl/hazardDecode.sv ====
module hazardDecode (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  instrValid,
    input  hazardPkg::instrT      instr,
    input  logic                  stall,
    output hazardPkg::decodeInfoT decodeInfo
);
    import hazardPkg::*;

    logic       validD;
    instrT      instrD;
    logic [5:0] opcode;
    logic [5:0] funct;
    regIdxT     rs;
    regIdxT     rt;
    regIdxT     rd;
    logic       known;

    ////////////////////////////////////////////////////////////////////////////
    // IF/ID register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validD <= 1'b0;
        end else if (!stall) begin
            validD <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            instrD <= instr;
        end
    end

    assign opcode = instrD[31:26];
    assign rs     = instrD[25:21];
    assign rt     = instrD[20:16];
    assign rd     = instrD[15:11];
    assign funct  = instrD[5:0];

    ////////////////////////////////////////////////////////////////////////////
    // Decode table
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        decodeInfo = '0;
        known      = 1'b0;
        if (validD) begin
            decodeInfo.instr = instrD;
            decodeInfo.valid = 1'b1;
            case (opcode)
                OP_R: begin
                    case (funct)
                        FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU: begin
                            known               = 1'b1;
                            decodeInfo.srcRs    = rs;
                            decodeInfo.tuseRs   = 2'd1;
                            decodeInfo.srcRt    = rt;
                            decodeInfo.tuseRt   = 2'd1;
                            decodeInfo.dest     = rd;
                            decodeInfo.tnew     = 2'd1;
                            decodeInfo.regWrite = 1'b1;
                        end
                        FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
                            known                = 1'b1;
                            decodeInfo.srcRs     = rs;
                            decodeInfo.tuseRs    = 2'd1;
                            decodeInfo.srcRt     = rt;
                            decodeInfo.tuseRt    = 2'd1;
                            decodeInfo.isMdStart = 1'b1;
                        end
                        FN_MFHI, FN_MFLO: begin
                            known                 = 1'b1;
                            decodeInfo.dest       = rd;
                            decodeInfo.tnew       = 2'd1;
                            decodeInfo.regWrite   = 1'b1;
                            decodeInfo.isMdAccess = 1'b1;
                        end
                        FN_MTHI, FN_MTLO: begin
                            known                 = 1'b1;
                            decodeInfo.srcRs      = rs;
                            decodeInfo.tuseRs     = 2'd1;
                            decodeInfo.isMdAccess = 1'b1;
                        end
                        FN_JR: begin
                            // Jump target needed in decode
                            known             = 1'b1;
                            decodeInfo.srcRs  = rs;
                            decodeInfo.tuseRs = 2'd0;
                        end
                        default: ;
                    endcase
                end
                OP_ORI, OP_ADDI, OP_ANDI: begin
                    known               = 1'b1;
                    decodeInfo.srcRs    = rs;
                    decodeInfo.tuseRs   = 2'd1;
                    decodeInfo.dest     = rt;
                    decodeInfo.tnew     = 2'd1;
                    decodeInfo.regWrite = 1'b1;
                end
                OP_LUI: begin
                    known               = 1'b1;
                    decodeInfo.dest     = rt;
                    decodeInfo.tnew     = 2'd1;
                    decodeInfo.regWrite = 1'b1;
                end
                OP_LW, OP_LB, OP_LH: begin
                    known               = 1'b1;
                    decodeInfo.srcRs    = rs;
                    decodeInfo.tuseRs   = 2'd1;
                    decodeInfo.dest     = rt;
                    decodeInfo.tnew     = 2'd2;
                    decodeInfo.regWrite = 1'b1;
                end
                OP_SW, OP_SB, OP_SH: begin
                    // Store data is not needed until the memory stage
                    known             = 1'b1;
                    decodeInfo.srcRs  = rs;
                    decodeInfo.tuseRs = 2'd1;
                    decodeInfo.srcRt  = rt;
                    decodeInfo.tuseRt = 2'd2;
                end
                OP_BEQ, OP_BNE: begin
                    known             = 1'b1;
                    decodeInfo.srcRs  = rs;
                    decodeInfo.tuseRs = 2'd0;
                    decodeInfo.srcRt  = rt;
                    decodeInfo.tuseRt = 2'd0;
                end
                OP_J: begin
                    known = 1'b1;
                end
                OP_JAL: begin
                    known               = 1'b1;
                    decodeInfo.dest     = 5'd31;
                    decodeInfo.tnew     = 2'd0;
                    decodeInfo.regWrite = 1'b1;
                end
                OP_COP0: begin
                    case (rs)
                        COP0_MFC0: begin
                            known               = 1'b1;
                            decodeInfo.dest     = rt;
                            decodeInfo.tnew     = 2'd2;
                            decodeInfo.regWrite = 1'b1;
                        end
                        COP0_MTC0: begin
                            known             = 1'b1;
                            decodeInfo.srcRt  = rt;
                            decodeInfo.tuseRt = 2'd2;
                        end
                        default: begin
                            if (funct == FN_ERET) begin
                                known             = 1'b1;
                                decodeInfo.isEret = 1'b1;
                            end
                        end
                    endcase
                end
                default: ;
            endcase
            if (!known) begin
                decodeInfo = '0;
            end
        end
    end

endmodule

// ==== hdl/hazardExecute.sv ====
module hazardExecute #(
    parameter int unsigned MULT_CYCLES = 5,
    parameter int unsigned DIV_CYCLES  = 10
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  stall,
    input  hazardPkg::decodeInfoT decodeInfo,
    output hazardPkg::stageInfoT  stageE,
    output hazardPkg::stageInfoT  stageM,
    output logic                  mduBusy
);
    import hazardPkg::*;

    localparam mduCountT MULT_LOAD = mduCountT'(MULT_CYCLES);
    localparam mduCountT DIV_LOAD  = mduCountT'(DIV_CYCLES);

    stageInfoT nextE;
    stageInfoT nextM;
    mduCountT  mduCount;
    logic      isDivE;

    ////////////////////////////////////////////////////////////////////////////
    // E and M stage records
    ////////////////////////////////////////////////////////////////////////////

    // Bubble into E while decode is stalled
    always_comb begin
        nextE = '0;
        if (!stall) begin
            nextE.instr     = decodeInfo.instr;
            nextE.valid     = decodeInfo.valid;
            nextE.dest      = decodeInfo.dest;
            nextE.tnew      = decodeInfo.tnew;
            nextE.regWrite  = decodeInfo.regWrite;
            nextE.isMdStart = decodeInfo.isMdStart;
            nextE.isMtc0Epc = decodeInfo.valid
                && (decodeInfo.instr[31:26] == OP_COP0)
                && (decodeInfo.instr[25:21] == COP0_MTC0)
                && (decodeInfo.instr[15:11] == EPC_REG);
        end
    end

    // One cycle closer to the result
    always_comb begin
        nextM = stageE;
        if (stageE.tnew != '0) begin
            nextM.tnew = stageE.tnew - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stageE <= '0;
            stageM <= '0;
        end else begin
            stageE <= nextE;
            stageM <= nextM;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Multiply/divide busy countdown
    ////////////////////////////////////////////////////////////////////////////

    assign isDivE = (stageE.instr[5:0] == FN_DIV) || (stageE.instr[5:0] == FN_DIVU);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mduCount <= '0;
        end else if (stageE.isMdStart) begin
            mduCount <= isDivE ? DIV_LOAD : MULT_LOAD;
        end else if (mduCount != '0) begin
            mduCount <= mduCount - 4'd1;
        end
    end

    assign mduBusy = (mduCount != '0);

endmodule

// ==== hdl/hazardPkg.sv ====
package hazardPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0] instrT;
    typedef logic [4:0]  regIdxT;
    // Cycles until a source is needed or a result is ready
    typedef logic [1:0]  stageTimeT;
    typedef logic [3:0]  mduCountT;

    ////////////////////////////////////////////////////////////////////////////
    // Opcodes
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [5:0] OP_R    = 6'h00;
    localparam logic [5:0] OP_ORI  = 6'h0d;
    localparam logic [5:0] OP_ADDI = 6'h08;
    localparam logic [5:0] OP_ANDI = 6'h0c;
    localparam logic [5:0] OP_LUI  = 6'h0f;
    localparam logic [5:0] OP_LW   = 6'h23;
    localparam logic [5:0] OP_LB   = 6'h20;
    localparam logic [5:0] OP_LH   = 6'h21;
    localparam logic [5:0] OP_SW   = 6'h2b;
    localparam logic [5:0] OP_SB   = 6'h28;
    localparam logic [5:0] OP_SH   = 6'h29;
    localparam logic [5:0] OP_BEQ  = 6'h04;
    localparam logic [5:0] OP_BNE  = 6'h05;
    localparam logic [5:0] OP_J    = 6'h02;
    localparam logic [5:0] OP_JAL  = 6'h03;
    localparam logic [5:0] OP_COP0 = 6'h10;

    // Function field of R-type and COP0 instructions
    localparam logic [5:0] FN_ADD   = 6'h20;
    localparam logic [5:0] FN_SUB   = 6'h22;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_SLT   = 6'h2a;
    localparam logic [5:0] FN_SLTU  = 6'h2b;
    localparam logic [5:0] FN_MULT  = 6'h18;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_DIV   = 6'h1a;
    localparam logic [5:0] FN_DIVU  = 6'h1b;
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_JR    = 6'h08;
    localparam logic [5:0] FN_ERET  = 6'h18;

    // COP0 rs field
    localparam logic [4:0] COP0_MFC0 = 5'd0;
    localparam logic [4:0] COP0_MTC0 = 5'd4;
    localparam regIdxT     EPC_REG   = 5'd14;

    ////////////////////////////////////////////////////////////////////////////
    // Stage records
    ////////////////////////////////////////////////////////////////////////////

    // Zero source index means the source is not read
    typedef struct packed {
        instrT     instr;
        logic      valid;
        regIdxT    srcRs;
        regIdxT    srcRt;
        stageTimeT tuseRs;
        stageTimeT tuseRt;
        regIdxT    dest;
        stageTimeT tnew;
        logic      regWrite;
        logic      isMdStart;
        logic      isMdAccess;
        logic      isEret;
    } decodeInfoT;

    typedef struct packed {
        instrT     instr;
        logic      valid;
        regIdxT    dest;
        stageTimeT tnew;
        logic      regWrite;
        logic      isMtc0Epc;
        logic      isMdStart;
    } stageInfoT;

endpackage

// ==== hdl/hazardResult.sv ====
module hazardResult (
    input  hazardPkg::decodeInfoT decodeInfo,
    input  hazardPkg::stageInfoT  stageE,
    input  hazardPkg::stageInfoT  stageM,
    input  logic                  mduBusy,
    output logic                  stall
);
    import hazardPkg::*;

    logic rsHitE;
    logic rsHitM;
    logic rtHitE;
    logic rtHitM;
    logic dataStall;
    logic mduStall;
    logic eretStall;

    // Source is needed before the producer in this stage has its result
    function automatic logic srcHit(
        input regIdxT    src,
        input stageTimeT tuse,
        input stageInfoT stage
    );
        return (src != '0)
            && stage.valid
            && stage.regWrite
            && (src == stage.dest)
            && (tuse < stage.tnew);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Data hazards
    ////////////////////////////////////////////////////////////////////////////

    assign rsHitE = srcHit(decodeInfo.srcRs, decodeInfo.tuseRs, stageE);
    assign rsHitM = srcHit(decodeInfo.srcRs, decodeInfo.tuseRs, stageM);
    assign rtHitE = srcHit(decodeInfo.srcRt, decodeInfo.tuseRt, stageE);
    assign rtHitM = srcHit(decodeInfo.srcRt, decodeInfo.tuseRt, stageM);

    assign dataStall = rsHitE | rsHitM | rtHitE | rtHitM;

    ////////////////////////////////////////////////////////////////////////////
    // Structural hazards
    ////////////////////////////////////////////////////////////////////////////

    // HI/LO access or a new operation waits for the unit to drain
    assign mduStall = (decodeInfo.isMdAccess || decodeInfo.isMdStart)
        && (mduBusy || stageE.isMdStart);

    // eret must see the updated EPC
    assign eretStall = decodeInfo.isEret && (stageE.isMtc0Epc || stageM.isMtc0Epc);

    assign stall = dataStall | mduStall | eretStall;

endmodule

// ==== hdl/pipeHazard.sv ====
module pipeHazard #(
    parameter int unsigned MULT_CYCLES = 5,
    parameter int unsigned DIV_CYCLES  = 10
) (
    input  logic             clk,
    input  logic             arstN,
    input  logic             instrValid,
    input  hazardPkg::instrT instr,
    output logic             stall,
    output logic             issueValid,
    output hazardPkg::instrT issueInstr
);
    import hazardPkg::*;

    decodeInfoT decodeInfo;
    stageInfoT  stageE;
    stageInfoT  stageM;
    logic       mduBusy;

    hazardDecode decode0 (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .stall      (stall),
        .decodeInfo (decodeInfo)
    );

    hazardExecute #(
        .MULT_CYCLES (MULT_CYCLES),
        .DIV_CYCLES  (DIV_CYCLES)
    ) execute0 (
        .clk        (clk),
        .arstN      (arstN),
        .stall      (stall),
        .decodeInfo (decodeInfo),
        .stageE     (stageE),
        .stageM     (stageM),
        .mduBusy    (mduBusy)
    );

    hazardResult result0 (
        .decodeInfo (decodeInfo),
        .stageE     (stageE),
        .stageM     (stageM),
        .mduBusy    (mduBusy),
        .stall      (stall)
    );

    // Issue strobe is the instruction entering execute
    assign issueValid = stageE.valid;
    assign issueInstr = stageE.instr;

endmodule

// ==== pipeHazard.f ====
hdl/hazardPkg.sv
hdl/hazardDecode.sv
hdl/hazardExecute.sv
hdl/hazardResult.sv
hdl/pipeHazard.sv
tests/pipeHazard_properties.sv
tests/pipeHazardTb.sv

// ==== tests/pipeHazardTb.sv ====
module pipeHazardTb;
    timeunit 1ns;
    timeprecision 1ps;
    import hazardPkg::*;

    localparam int unsigned MULT_CYCLES = 5;
    localparam int unsigned DIV_CYCLES  = 10;
    localparam int NUM_INSTR = 3000;
    localparam int WATCHDOG_CYCLES = NUM_INSTR * (DIV_CYCLES + 4);

    logic  clk;
    logic  arstN;
    logic  instrValid;
    instrT instr;
    logic  stall;
    logic  issueValid;
    instrT issueInstr;

    integer    seed;
    logic      refValidD;
    instrT     refInstrD;
    stageInfoT refE;
    stageInfoT refM;
    int        refCount;
    int        acceptedCount;
    logic      stallNow;
    logic      feeding;
    logic      midResetDone;
    instrT     orderQ[$];

    pipeHazard #(
        .MULT_CYCLES (MULT_CYCLES),
        .DIV_CYCLES  (DIV_CYCLES)
    ) dut0 (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instr      (instr),
        .stall      (stall),
        .issueValid (issueValid),
        .issueInstr (issueInstr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            failRun($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compareInstr(input string name, input instrT got, input instrT exp);
        if (got !== exp) begin
            failRun($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Registers 0 to 7 only, so hazards show up often
    function automatic instrT randomInstr();
        int         kind;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        logic [15:0] imm;
        logic       pick;
        kind = int'($unsigned($random(seed)) % 32'd20);
        rs   = regIdxT'($random(seed) & 7);
        rt   = regIdxT'($random(seed) & 7);
        rd   = regIdxT'($random(seed) & 7);
        imm  = 16'($random(seed));
        pick = 1'($random(seed));
        case (kind)
            0, 1: return {OP_R, rs, rt, rd, 5'd0, pick ? FN_ADD : FN_SUB};
            2: return {OP_R, rs, rt, rd, 5'd0, pick ? FN_AND : FN_OR};
            3: return {OP_R, rs, rt, rd, 5'd0, pick ? FN_SLT : FN_SLTU};
            4: return {pick ? OP_ORI : OP_ADDI, rs, rt, imm};
            5: return {OP_ANDI, rs, rt, imm};
            6: return {OP_LUI, 5'd0, rt, imm};
            7: return {pick ? OP_LW : OP_LB, rs, rt, imm};
            8: return {OP_LH, rs, rt, imm};
            9: return {pick ? OP_SW : OP_SB, rs, rt, imm};
            10: return {OP_SH, rs, rt, imm};
            11: return {pick ? OP_BEQ : OP_BNE, rs, rt, imm};
            12: return {pick ? OP_J : OP_JAL, 10'd0, imm};
            13: return {OP_R, rs, 15'd0, FN_JR};
            14: begin
                if (imm[0]) begin
                    return {OP_R, rs, rt, 10'd0, pick ? FN_MULT : FN_MULTU};
                end
                return {OP_R, rs, rt, 10'd0, pick ? FN_DIV : FN_DIVU};
            end
            15: return {OP_R, 10'd0, rd, 5'd0, pick ? FN_MFHI : FN_MFLO};
            16: return {OP_R, rs, 15'd0, pick ? FN_MTHI : FN_MTLO};
            17: return {OP_COP0, COP0_MFC0, rt, rd, 11'd0};
            18: return {OP_COP0, COP0_MTC0, rt, pick ? EPC_REG : regIdxT'(imm[3:0]), 11'd0};
            default: return {OP_COP0, 5'h10, 15'd0, FN_ERET};
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic decodeInfoT decodeRef(input logic v, input instrT w);
        decodeInfoT d;
        logic [5:0] op;
        logic [5:0] fn;
        op = w[31:26];
        fn = w[5:0];
        d = '0;
        d.instr = w;
        d.valid = 1'b1;
        if (!v) begin
            return '0;
        end
        if (op == OP_R && fn inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_SLTU}) begin
            d.srcRs = w[25:21]; d.tuseRs = 2'd1; d.srcRt = w[20:16]; d.tuseRt = 2'd1;
            d.dest = w[15:11]; d.tnew = 2'd1; d.regWrite = 1'b1;
        end else if (op == OP_R && fn inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU}) begin
            d.srcRs = w[25:21]; d.tuseRs = 2'd1; d.srcRt = w[20:16]; d.tuseRt = 2'd1;
            d.isMdStart = 1'b1;
        end else if (op == OP_R && fn inside {FN_MFHI, FN_MFLO}) begin
            d.dest = w[15:11]; d.tnew = 2'd1; d.regWrite = 1'b1; d.isMdAccess = 1'b1;
        end else if (op == OP_R && fn inside {FN_MTHI, FN_MTLO}) begin
            d.srcRs = w[25:21]; d.tuseRs = 2'd1; d.isMdAccess = 1'b1;
        end else if (op == OP_R && fn == FN_JR) begin
            d.srcRs = w[25:21];
        end else if (op inside {OP_ORI, OP_ADDI, OP_ANDI, OP_LW, OP_LB, OP_LH}) begin
            d.srcRs = w[25:21]; d.tuseRs = 2'd1; d.dest = w[20:16]; d.regWrite = 1'b1;
            d.tnew = (op inside {OP_LW, OP_LB, OP_LH}) ? 2'd2 : 2'd1;
        end else if (op == OP_LUI) begin
            d.dest = w[20:16]; d.tnew = 2'd1; d.regWrite = 1'b1;
        end else if (op inside {OP_SW, OP_SB, OP_SH}) begin
            d.srcRs = w[25:21]; d.tuseRs = 2'd1; d.srcRt = w[20:16]; d.tuseRt = 2'd2;
        end else if (op inside {OP_BEQ, OP_BNE}) begin
            d.srcRs = w[25:21]; d.srcRt = w[20:16];
        end else if (op == OP_J) begin
            d.valid = 1'b1;
        end else if (op == OP_JAL) begin
            d.dest = 5'd31; d.regWrite = 1'b1;
        end else if (op == OP_COP0 && w[25:21] == COP0_MFC0) begin
            d.dest = w[20:16]; d.tnew = 2'd2; d.regWrite = 1'b1;
        end else if (op == OP_COP0 && w[25:21] == COP0_MTC0) begin
            d.srcRt = w[20:16]; d.tuseRt = 2'd2;
        end else if (op == OP_COP0 && fn == FN_ERET) begin
            d.isEret = 1'b1;
        end else begin
            return '0;
        end
        return d;
    endfunction

    function automatic logic readsTooEarly(input regIdxT src, input stageTimeT tuse,
                                           input stageInfoT st);
        return src != 5'd0 && st.valid && st.regWrite && src == st.dest && tuse < st.tnew;
    endfunction

    function automatic logic predictStall(input decodeInfoT d);
        logic data;
        logic mdu;
        logic eret;
        data = readsTooEarly(d.srcRs, d.tuseRs, refE) || readsTooEarly(d.srcRs, d.tuseRs, refM)
            || readsTooEarly(d.srcRt, d.tuseRt, refE) || readsTooEarly(d.srcRt, d.tuseRt, refM);
        mdu  = (d.isMdAccess || d.isMdStart) && (refCount != 0 || refE.isMdStart);
        eret = d.isEret && (refE.isMtc0Epc || refM.isMtc0Epc);
        return data || mdu || eret;
    endfunction

    task automatic resetModel();
        refValidD = 1'b0;
        refInstrD = '0;
        refE      = '0;
        refM      = '0;
        refCount  = 0;
        orderQ.delete();
    endtask

    // Model state advance at a rising edge
    task automatic advanceModel(input logic st);
        decodeInfoT d;
        stageInfoT  nextE;
        d = decodeRef(refValidD, refInstrD);
        nextE = '0;
        if (!st) begin
            nextE.instr     = d.instr;
            nextE.valid     = d.valid;
            nextE.dest      = d.dest;
            nextE.tnew      = d.tnew;
            nextE.regWrite  = d.regWrite;
            nextE.isMdStart = d.isMdStart;
            nextE.isMtc0Epc = d.valid && d.instr[31:21] == {OP_COP0, COP0_MTC0}
                && d.instr[15:11] == EPC_REG;
        end
        if (refE.isMdStart) begin
            refCount = (refE.instr[5:0] inside {FN_DIV, FN_DIVU}) ? DIV_CYCLES : MULT_CYCLES;
        end else if (refCount > 0) begin
            refCount = refCount - 1;
        end
        refM = refE;
        if (refM.tnew != 2'd0) begin
            refM.tnew = refM.tnew - 2'd1;
        end
        refE = nextE;
        if (!st) begin
            if (instrValid) begin
                orderQ.push_back(instr);
                acceptedCount++;
            end
            refValidD = instrValid;
            refInstrD = instr;
        end
    endtask

    task automatic offerNext();
        instrValid = feeding && (($random(seed) & 7) != 0);
        instr      = randomInstr();
    endtask

    // Check mid cycle, advance at the edge, drive 1 ns later
    task automatic runCycle();
        @(negedge clk);
        stallNow = predictStall(decodeRef(refValidD, refInstrD));
        compareBit("stall", stall, stallNow);
        compareBit("issueValid", issueValid, refE.valid);
        if (refE.valid) begin
            compareInstr("issueInstr", issueInstr, refE.instr);
            if (orderQ.size() == 0) begin
                failRun("An instruction issued that was never accepted");
            end
            compareInstr("issueOrder", issueInstr, orderQ.pop_front());
        end
        @(posedge clk);
        advanceModel(stallNow);
        #1;
        if (!stallNow) begin
            offerNext();
        end
    endtask

    task automatic applyMidReset();
        arstN      = 1'b0;
        instrValid = 1'b0;
        resetModel();
        repeat (2) begin
            @(negedge clk);
            compareBit("stall", stall, 1'b0);
            compareBit("issueValid", issueValid, 1'b0);
        end
        @(posedge clk);
        #1;
        arstN = 1'b1;
        offerNext();
    endtask

    initial begin
        seed          = 32'hba2a47b3;
        arstN         = 1'b0;
        instrValid    = 1'b0;
        instr         = '0;
        feeding       = 1'b1;
        midResetDone  = 1'b0;
        acceptedCount = 0;
        resetModel();
        repeat (8) @(posedge clk);
        #1;
        arstN = 1'b1;
        offerNext();
        while (acceptedCount < NUM_INSTR) begin
            runCycle();
            if (!midResetDone && acceptedCount >= NUM_INSTR / 2) begin
                midResetDone = 1'b1;
                applyMidReset();
            end
        end
        // Drain the pipeline
        feeding = 1'b0;
        repeat (DIV_CYCLES + 8) runCycle();
        if (orderQ.size() != 0) begin
            failRun("Accepted instructions never issued");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        failRun("Run hung before all instructions were issued");
    end

endmodule

// ==== tests/pipeHazard_properties.sv ====
module pipeHazard_properties (
    input logic                 clk,
    input logic                 arstN,
    input logic                 stall,
    input hazardPkg::stageInfoT stageE,
    input logic                 mduBusy
);
    timeunit 1ns;
    timeprecision 1ps;
    import hazardPkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Stall and issue behavior
    ////////////////////////////////////////////////////////////////////////////

    // Decode is empty right after reset
    stallAfterReset: assert property (@(posedge clk) $rose(arstN) |-> !stall)
        else $error("stall high after reset");

    stallMakesBubble: assert property (@(posedge clk) disable iff (!arstN)
        stall |=> !stageE.valid)
        else $error("stalled cycle issued an instruction");

    // Countdown starts only from a mult or div in E
    busyNeedsStart: assert property (@(posedge clk) disable iff (!arstN)
        $rose(mduBusy) |-> $past(stageE.isMdStart))
        else $error("mduBusy rose without a start");

endmodule

bind hazardExecute pipeHazard_properties props0 (
    .clk     (clk),
    .arstN   (arstN),
    .stall   (stall),
    .stageE  (stageE),
    .mduBusy (mduBusy)
);
